//--- src/l1_cache_params.svh
// L1 cache geometry and latency
`ifndef L1_CACHE_PARAMS_SVH
`define L1_CACHE_PARAMS_SVH

`define L1_WORD_BITS      32
`define L1_LINE_BITS      128
// Fixed at two by the one-bit LRU
`define L1_WAYS           2
`define L1_SET_BITS       3
`define L1_ADDR_BITS      12
`define L1_MEM_LATENCY    4
`define L1_OOO_TAG_BITS   8

// Address fields: [1:0] ignored, [3:2] word, [4] bank, then set, then tag
`define L1_WORD_LSB       2
`define L1_WORD_SEL_BITS  2
`define L1_BANK_BIT       4
`define L1_OFFSET_BITS    4
`define L1_SET_LSB        5
`define L1_TAG_LSB        (`L1_SET_LSB + `L1_SET_BITS)
`define L1_TAG_BITS       (`L1_ADDR_BITS - `L1_TAG_LSB)
`define L1_LINE_ADDR_BITS (`L1_ADDR_BITS - `L1_OFFSET_BITS)
`define L1_MEM_LINES      (1 << `L1_LINE_ADDR_BITS)

// After reset the word at word address w holds w ^ 32'h5a5a_0000
`define L1_MEM_INIT_XOR   32'h5a5a_0000

`endif

//--- src/l1_cache_pkg.sv
// L1 cache types
`default_nettype none

package l1_cache_pkg;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE
    } cache_op_e;

    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_LOOKUP,
        BANK_MISS_WAIT,
        BANK_REFILL
    } bank_state_e;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WRITE,
        MEM_READ,
        MEM_DONE
    } mem_state_e;

    // Miss arbiter holds one grant per memory transaction
    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

endpackage

`default_nettype wire

//--- src/cache_bank.sv
// Two-way cache bank
`timescale 1ns/1ns
`default_nettype none
`include "l1_cache_params.svh"

module cache_bank
    import l1_cache_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    input  cache_op_e                     req_op,
    input  logic [`L1_ADDR_BITS-1:0]      req_addr,
    input  logic [`L1_WORD_BITS-1:0]      req_data,
    input  logic [`L1_OOO_TAG_BITS-1:0]   req_tag,
    input  logic                          fill_valid,
    input  logic [`L1_LINE_BITS-1:0]      fill_line,
    output logic                          busy,
    output logic                          resp_valid,
    output logic [`L1_WORD_BITS-1:0]      resp_data,
    output logic [`L1_OOO_TAG_BITS-1:0]   resp_tag,
    output logic                          resp_hit,
    output logic                          mem_req,
    output logic                          mem_wb,
    output logic [`L1_LINE_ADDR_BITS-1:0] mem_wb_addr,
    output logic [`L1_LINE_BITS-1:0]      mem_wb_line,
    output logic [`L1_LINE_ADDR_BITS-1:0] mem_rd_addr
);

    localparam int SETS = 1 << `L1_SET_BITS;

    bank_state_e state;

    // Tag, data and metadata stores
    logic [`L1_TAG_BITS-1:0]  tag_arr   [SETS][`L1_WAYS];
    logic [`L1_LINE_BITS-1:0] data_arr  [SETS][`L1_WAYS];
    logic [`L1_WAYS-1:0]      valid_arr [SETS];
    logic [`L1_WAYS-1:0]      dirty_arr [SETS];
    // Per set, the index of the least recently used way
    logic [SETS-1:0]          lru_arr;

    // Request buffer
    cache_op_e                    op_buf;
    logic [`L1_ADDR_BITS-1:0]     addr_buf;
    logic [`L1_WORD_BITS-1:0]     data_buf;
    logic [`L1_OOO_TAG_BITS-1:0]  rtag_buf;

    // Line and way held from lookup or fill until the refill cycle
    logic [`L1_LINE_BITS-1:0]     line_buf;
    logic                         way_buf;
    logic                         hit_buf;

    logic [`L1_SET_BITS-1:0]      set_idx;
    logic [`L1_TAG_BITS-1:0]      line_tag;
    logic [`L1_WORD_SEL_BITS-1:0] word_sel;
    logic [`L1_WAYS-1:0]          way_hit;
    logic                         hit;
    logic                         hit_way;
    logic                         victim_way;
    logic                         is_store;
    logic [`L1_LINE_BITS-1:0]     new_line;

    assign set_idx  = addr_buf[`L1_SET_LSB +: `L1_SET_BITS];
    assign line_tag = addr_buf[`L1_TAG_LSB +: `L1_TAG_BITS];
    assign word_sel = addr_buf[`L1_WORD_LSB +: `L1_WORD_SEL_BITS];
    assign is_store = (op_buf == OP_STORE);

    // Hit check over both ways
    always_comb begin
        for (int w = 0; w < `L1_WAYS; w++) begin
            way_hit[w] = valid_arr[set_idx][w] && (tag_arr[set_idx][w] == line_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // Replacement: first invalid way, else the LRU way
    always_comb begin
        if (!valid_arr[set_idx][0]) begin
            victim_way = 1'b0;
        end else if (!valid_arr[set_idx][1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_arr[set_idx];
        end
    end

    // Store word merged into the held line
    always_comb begin
        new_line = line_buf;
        if (is_store) begin
            new_line[word_sel*`L1_WORD_BITS +: `L1_WORD_BITS] = data_buf;
        end
    end

    assign busy    = (state != BANK_IDLE);
    assign mem_req = (state == BANK_MISS_WAIT);

    // Victim stays put while waiting, so eviction data comes straight from the stores
    assign mem_wb      = valid_arr[set_idx][way_buf] && dirty_arr[set_idx][way_buf];
    assign mem_wb_addr = {tag_arr[set_idx][way_buf], set_idx, addr_buf[`L1_BANK_BIT]};
    assign mem_wb_line = data_arr[set_idx][way_buf];
    assign mem_rd_addr = addr_buf[`L1_ADDR_BITS-1:`L1_OFFSET_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= BANK_IDLE;
            resp_valid <= 1'b0;
            lru_arr    <= '0;
            for (int s = 0; s < SETS; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
            end
        end else begin
            resp_valid <= 1'b0;
            case (state)
                BANK_IDLE: begin
                    if (req_valid && req_op != OP_NONE) begin
                        state <= BANK_LOOKUP;
                    end
                end
                BANK_LOOKUP: begin
                    state <= hit ? BANK_REFILL : BANK_MISS_WAIT;
                end
                BANK_MISS_WAIT: begin
                    if (fill_valid) begin
                        state <= BANK_REFILL;
                    end
                end
                BANK_REFILL: begin
                    valid_arr[set_idx][way_buf] <= 1'b1;
                    dirty_arr[set_idx][way_buf] <= is_store ||
                                                   (hit_buf && dirty_arr[set_idx][way_buf]);
                    lru_arr[set_idx] <= ~way_buf;
                    resp_valid       <= 1'b1;
                    state            <= BANK_IDLE;
                end
                default: state <= BANK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BANK_IDLE && req_valid) begin
            op_buf   <= req_op;
            addr_buf <= req_addr;
            data_buf <= req_data;
            rtag_buf <= req_tag;
        end
        if (state == BANK_LOOKUP) begin
            hit_buf  <= hit;
            way_buf  <= hit ? hit_way : victim_way;
            line_buf <= data_arr[set_idx][hit_way];
        end
        if (state == BANK_MISS_WAIT && fill_valid) begin
            line_buf <= fill_line;
        end
        if (state == BANK_REFILL) begin
            tag_arr[set_idx][way_buf]  <= line_tag;
            data_arr[set_idx][way_buf] <= new_line;
            // Old word goes back as rewind data for stores
            resp_data <= line_buf[word_sel*`L1_WORD_BITS +: `L1_WORD_BITS];
            resp_tag  <= rtag_buf;
            resp_hit  <= hit_buf;
        end
    end

endmodule

`default_nettype wire

//--- src/miss_arbiter.sv
// Round-robin miss arbiter
`timescale 1ns/1ns
`default_nettype none
`include "l1_cache_params.svh"

module miss_arbiter
    import l1_cache_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_req_0,
    input  logic                          mem_wb_0,
    input  logic [`L1_LINE_ADDR_BITS-1:0] mem_wb_addr_0,
    input  logic [`L1_LINE_BITS-1:0]      mem_wb_line_0,
    input  logic [`L1_LINE_ADDR_BITS-1:0] mem_rd_addr_0,
    input  logic                          mem_req_1,
    input  logic                          mem_wb_1,
    input  logic [`L1_LINE_ADDR_BITS-1:0] mem_wb_addr_1,
    input  logic [`L1_LINE_BITS-1:0]      mem_wb_line_1,
    input  logic [`L1_LINE_ADDR_BITS-1:0] mem_rd_addr_1,
    input  logic                          mem_done,
    input  logic [`L1_LINE_BITS-1:0]      mem_rd_line,
    output logic                          fill_valid_0,
    output logic                          fill_valid_1,
    output logic [`L1_LINE_BITS-1:0]      fill_line,
    output logic                          mem_start,
    output logic                          mem_wb,
    output logic [`L1_LINE_ADDR_BITS-1:0] mem_wb_addr,
    output logic [`L1_LINE_BITS-1:0]      mem_wb_line,
    output logic [`L1_LINE_ADDR_BITS-1:0] mem_rd_addr
);

    arb_state_e state;
    // Active bank, which also serves as the last-served pointer
    logic       grant;
    // Bank just filled, blocked until its request drops
    logic [1:0] served;
    logic [1:0] want;
    logic       pick;

    assign want = {mem_req_1 && !served[1], mem_req_0 && !served[0]};

    // Both waiting goes to the bank not served last
    assign pick = (want[0] && want[1]) ? ~grant : want[1];

    assign fill_valid_0 = mem_done && (state == ARB_BUSY) && !grant;
    assign fill_valid_1 = mem_done && (state == ARB_BUSY) && grant;
    assign fill_line    = mem_rd_line;

    assign mem_wb      = grant ? mem_wb_1      : mem_wb_0;
    assign mem_wb_addr = grant ? mem_wb_addr_1 : mem_wb_addr_0;
    assign mem_wb_line = grant ? mem_wb_line_1 : mem_wb_line_0;
    assign mem_rd_addr = grant ? mem_rd_addr_1 : mem_rd_addr_0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ARB_IDLE;
            grant     <= 1'b1;
            served    <= '0;
            mem_start <= 1'b0;
        end else begin
            mem_start <= 1'b0;
            served[0] <= fill_valid_0 || (served[0] && mem_req_0);
            served[1] <= fill_valid_1 || (served[1] && mem_req_1);
            case (state)
                ARB_IDLE: begin
                    if (|want) begin
                        grant     <= pick;
                        mem_start <= 1'b1;
                        state     <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (mem_done) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/backing_memory.sv
// Fixed-latency backing memory
`timescale 1ns/1ns
`default_nettype none
`include "l1_cache_params.svh"

module backing_memory
    import l1_cache_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_start,
    input  logic                          mem_wb,
    input  logic [`L1_LINE_ADDR_BITS-1:0] mem_wb_addr,
    input  logic [`L1_LINE_BITS-1:0]      mem_wb_line,
    input  logic [`L1_LINE_ADDR_BITS-1:0] mem_rd_addr,
    output logic                          mem_done,
    output logic [`L1_LINE_BITS-1:0]      mem_rd_line
);

    localparam int WORDS    = `L1_LINE_BITS / `L1_WORD_BITS;
    localparam int CNT_BITS = $clog2(`L1_MEM_LATENCY + 1);

    mem_state_e state;
    logic [CNT_BITS-1:0]           cnt;
    logic [`L1_LINE_BITS-1:0]      mem [`L1_MEM_LINES];

    logic [`L1_LINE_ADDR_BITS-1:0] wb_addr_buf;
    logic [`L1_LINE_BITS-1:0]      wb_line_buf;
    logic [`L1_LINE_ADDR_BITS-1:0] rd_addr_buf;

    assign mem_done = (state == MEM_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MEM_IDLE;
            cnt   <= '0;
            // Initial contents from the word address rule
            for (int i = 0; i < `L1_MEM_LINES; i++) begin
                for (int j = 0; j < WORDS; j++) begin
                    mem[i][j*`L1_WORD_BITS +: `L1_WORD_BITS] <= (i * WORDS + j) ^
                                                                `L1_MEM_INIT_XOR;
                end
            end
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (mem_start) begin
                        state <= mem_wb ? MEM_WRITE : MEM_READ;
                        cnt   <= CNT_BITS'(`L1_MEM_LATENCY - 1);
                    end
                end
                MEM_WRITE: begin
                    if (cnt == '0) begin
                        mem[wb_addr_buf] <= wb_line_buf;
                        state            <= MEM_READ;
                        cnt              <= CNT_BITS'(`L1_MEM_LATENCY - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                MEM_READ: begin
                    if (cnt == '0) begin
                        state <= MEM_DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MEM_IDLE && mem_start) begin
            wb_addr_buf <= mem_wb_addr;
            wb_line_buf <= mem_wb_line;
            rd_addr_buf <= mem_rd_addr;
        end
        // Write phase lands first, so a read of the same line sees it
        if (state == MEM_READ && cnt == '0) begin
            mem_rd_line <= mem[rd_addr_buf];
        end
    end

endmodule

`default_nettype wire

//--- src/l1_cache_top.sv
// Two-bank L1 data cache
`timescale 1ns/1ns
`default_nettype none
`include "l1_cache_params.svh"

module l1_cache_top
    import l1_cache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    input  cache_op_e                   req_op,
    input  logic [`L1_ADDR_BITS-1:0]    req_addr,
    input  logic [`L1_WORD_BITS-1:0]    req_data,
    input  logic [`L1_OOO_TAG_BITS-1:0] req_tag,
    output logic                        busy_0,
    output logic                        resp_valid_0,
    output logic [`L1_WORD_BITS-1:0]    resp_data_0,
    output logic [`L1_OOO_TAG_BITS-1:0] resp_tag_0,
    output logic                        resp_hit_0,
    output logic                        busy_1,
    output logic                        resp_valid_1,
    output logic [`L1_WORD_BITS-1:0]    resp_data_1,
    output logic [`L1_OOO_TAG_BITS-1:0] resp_tag_1,
    output logic                        resp_hit_1
);

    logic                          mem_req_0;
    logic                          mem_wb_0;
    logic [`L1_LINE_ADDR_BITS-1:0] mem_wb_addr_0;
    logic [`L1_LINE_BITS-1:0]      mem_wb_line_0;
    logic [`L1_LINE_ADDR_BITS-1:0] mem_rd_addr_0;
    logic                          fill_valid_0;
    logic                          mem_req_1;
    logic                          mem_wb_1;
    logic [`L1_LINE_ADDR_BITS-1:0] mem_wb_addr_1;
    logic [`L1_LINE_BITS-1:0]      mem_wb_line_1;
    logic [`L1_LINE_ADDR_BITS-1:0] mem_rd_addr_1;
    logic                          fill_valid_1;
    logic [`L1_LINE_BITS-1:0]      fill_line;
    logic                          mem_start;
    logic                          mem_wb;
    logic [`L1_LINE_ADDR_BITS-1:0] mem_wb_addr;
    logic [`L1_LINE_BITS-1:0]      mem_wb_line;
    logic [`L1_LINE_ADDR_BITS-1:0] mem_rd_addr;
    logic                          mem_done;
    logic [`L1_LINE_BITS-1:0]      mem_rd_line;
    logic                          req_valid_0;
    logic                          req_valid_1;

    // Bank chosen by address bit 4
    assign req_valid_0 = req_valid && !req_addr[`L1_BANK_BIT];
    assign req_valid_1 = req_valid && req_addr[`L1_BANK_BIT];

    cache_bank bank0_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid_0),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .req_tag    (req_tag),
        .fill_valid (fill_valid_0),
        .fill_line  (fill_line),
        .busy       (busy_0),
        .resp_valid (resp_valid_0),
        .resp_data  (resp_data_0),
        .resp_tag   (resp_tag_0),
        .resp_hit   (resp_hit_0),
        .mem_req    (mem_req_0),
        .mem_wb     (mem_wb_0),
        .mem_wb_addr(mem_wb_addr_0),
        .mem_wb_line(mem_wb_line_0),
        .mem_rd_addr(mem_rd_addr_0)
    );

    cache_bank bank1_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid_1),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .req_tag    (req_tag),
        .fill_valid (fill_valid_1),
        .fill_line  (fill_line),
        .busy       (busy_1),
        .resp_valid (resp_valid_1),
        .resp_data  (resp_data_1),
        .resp_tag   (resp_tag_1),
        .resp_hit   (resp_hit_1),
        .mem_req    (mem_req_1),
        .mem_wb     (mem_wb_1),
        .mem_wb_addr(mem_wb_addr_1),
        .mem_wb_line(mem_wb_line_1),
        .mem_rd_addr(mem_rd_addr_1)
    );

    miss_arbiter miss_arbiter_inst (
        .clk          (clk),
        .rst          (rst),
        .mem_req_0    (mem_req_0),
        .mem_wb_0     (mem_wb_0),
        .mem_wb_addr_0(mem_wb_addr_0),
        .mem_wb_line_0(mem_wb_line_0),
        .mem_rd_addr_0(mem_rd_addr_0),
        .mem_req_1    (mem_req_1),
        .mem_wb_1     (mem_wb_1),
        .mem_wb_addr_1(mem_wb_addr_1),
        .mem_wb_line_1(mem_wb_line_1),
        .mem_rd_addr_1(mem_rd_addr_1),
        .mem_done     (mem_done),
        .mem_rd_line  (mem_rd_line),
        .fill_valid_0 (fill_valid_0),
        .fill_valid_1 (fill_valid_1),
        .fill_line    (fill_line),
        .mem_start    (mem_start),
        .mem_wb       (mem_wb),
        .mem_wb_addr  (mem_wb_addr),
        .mem_wb_line  (mem_wb_line),
        .mem_rd_addr  (mem_rd_addr)
    );

    backing_memory backing_memory_inst (
        .clk        (clk),
        .rst        (rst),
        .mem_start  (mem_start),
        .mem_wb     (mem_wb),
        .mem_wb_addr(mem_wb_addr),
        .mem_wb_line(mem_wb_line),
        .mem_rd_addr(mem_rd_addr),
        .mem_done   (mem_done),
        .mem_rd_line(mem_rd_line)
    );

endmodule

`default_nettype wire

//--- testbench/tb_l1_cache.sv
// L1 cache testbench
`timescale 1ns/1ns
`default_nettype none
`include "l1_cache_params.svh"

module tb_l1_cache
    import l1_cache_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT    = 200;
    localparam int N_RANDOM   = 40;
    localparam int N_MAX      = 64;
    localparam int HIT_LAT    = 2;
    localparam int MEM_WORDS  = 1 << (`L1_ADDR_BITS - `L1_WORD_LSB);
    localparam int SETS       = 1 << `L1_SET_BITS;

    // Hit field: 0 miss, 1 hit, 2 taken from the model
    typedef struct packed {
        cache_op_e                op;
        logic [`L1_ADDR_BITS-1:0] addr;
        logic [`L1_WORD_BITS-1:0] data;
        logic                     second;
        logic [1:0]               hit_exp;
    } stim_t;

    stim_t stim [N_MAX];
    int    n_entries;

    logic                        clk;
    logic                        rst;
    logic                        req_valid;
    cache_op_e                   req_op;
    logic [`L1_ADDR_BITS-1:0]    req_addr;
    logic [`L1_WORD_BITS-1:0]    req_data;
    logic [`L1_OOO_TAG_BITS-1:0] req_tag;
    logic                        busy_0;
    logic                        resp_valid_0;
    logic [`L1_WORD_BITS-1:0]    resp_data_0;
    logic [`L1_OOO_TAG_BITS-1:0] resp_tag_0;
    logic                        resp_hit_0;
    logic                        busy_1;
    logic                        resp_valid_1;
    logic [`L1_WORD_BITS-1:0]    resp_data_1;
    logic [`L1_OOO_TAG_BITS-1:0] resp_tag_1;
    logic                        resp_hit_1;

    // Reference word memory and tag model per bank
    logic [`L1_WORD_BITS-1:0] ref_mem [MEM_WORDS];
    logic [`L1_TAG_BITS-1:0]  mdl_tag [2][SETS][2];
    logic                     mdl_valid [2][SETS][2];
    logic                     mdl_lru [2][SETS];

    // Expected response per bank
    logic                        pend [2];
    logic [`L1_WORD_BITS-1:0]    exp_data [2];
    logic [`L1_OOO_TAG_BITS-1:0] exp_tag [2];
    logic                        exp_hit [2];
    int                          lat [2];

    int                          errors;
    int                          checks;
    logic                        timed_out;
    logic [`L1_OOO_TAG_BITS-1:0] next_tag;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    l1_cache_top l1_cache_top_inst (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .req_tag     (req_tag),
        .busy_0      (busy_0),
        .resp_valid_0(resp_valid_0),
        .resp_data_0 (resp_data_0),
        .resp_tag_0  (resp_tag_0),
        .resp_hit_0  (resp_hit_0),
        .busy_1      (busy_1),
        .resp_valid_1(resp_valid_1),
        .resp_data_1 (resp_data_1),
        .resp_tag_1  (resp_tag_1),
        .resp_hit_1  (resp_hit_1)
    );

    task automatic add_entry(input cache_op_e op, input logic [`L1_ADDR_BITS-1:0] addr,
                             input logic [`L1_WORD_BITS-1:0] data, input logic second,
                             input logic [1:0] hit_exp);
        stim[n_entries] = '{op, addr, data, second, hit_exp};
        n_entries++;
    endtask

    task automatic build_table();
        logic [1:0] tag;
        // Cold miss, then hits on the same line
        add_entry(OP_LOAD,  12'h000, 32'h0, 1'b0, 2'd0);
        add_entry(OP_LOAD,  12'h004, 32'h0, 1'b0, 2'd1);
        add_entry(OP_STORE, 12'h008, 32'hdead_beef, 1'b0, 2'd1);
        add_entry(OP_LOAD,  12'h008, 32'h0, 1'b0, 2'd1);
        // Three lines in set 0 of bank 0 push out the dirty line
        add_entry(OP_LOAD,  12'h100, 32'h0, 1'b0, 2'd0);
        add_entry(OP_LOAD,  12'h200, 32'h0, 1'b0, 2'd0);
        add_entry(OP_LOAD,  12'h008, 32'h0, 1'b0, 2'd0);
        // Misses in both banks on consecutive cycles
        add_entry(OP_LOAD,  12'h310, 32'h0, 1'b1, 2'd0);
        add_entry(OP_STORE, 12'h334, 32'h1234_5678, 1'b1, 2'd0);
        add_entry(OP_LOAD,  12'h334, 32'h0, 1'b0, 2'd1);
        // Random mix over three tags and two sets
        for (int i = 0; i < N_RANDOM; i++) begin
            tag = 2'($urandom % 3);
            add_entry(($urandom % 2) ? OP_STORE : OP_LOAD,
                      {2'b00, tag, 2'b00, 1'($urandom), 1'($urandom), 2'($urandom), 2'b00},
                      $urandom, ($urandom % 4) == 0, 2'd2);
        end
    endtask

    // Tag model with first-invalid-else-LRU replacement
    function automatic logic model_access(input logic [`L1_ADDR_BITS-1:0] addr);
        logic                    bank;
        logic [`L1_SET_BITS-1:0] set_idx;
        logic [`L1_TAG_BITS-1:0] tag;
        logic                    way;
        logic                    hit;
        bank    = addr[`L1_BANK_BIT];
        set_idx = addr[`L1_SET_LSB +: `L1_SET_BITS];
        tag     = addr[`L1_TAG_LSB +: `L1_TAG_BITS];
        hit     = 1'b0;
        way     = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (mdl_valid[bank][set_idx][w] && mdl_tag[bank][set_idx][w] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            if (!mdl_valid[bank][set_idx][0]) begin
                way = 1'b0;
            end else if (!mdl_valid[bank][set_idx][1]) begin
                way = 1'b1;
            end else begin
                way = mdl_lru[bank][set_idx];
            end
            mdl_valid[bank][set_idx][way] = 1'b1;
            mdl_tag[bank][set_idx][way]   = tag;
        end
        mdl_lru[bank][set_idx] = ~way;
        return hit;
    endfunction

    task automatic send_request(input cache_op_e op, input logic [`L1_ADDR_BITS-1:0] addr,
                                input logic [`L1_WORD_BITS-1:0] data, input logic [1:0] hit_exp);
        int   b;
        int   w;
        logic mhit;
        b    = addr[`L1_BANK_BIT];
        w    = addr[`L1_ADDR_BITS-1:`L1_WORD_LSB];
        mhit = model_access(addr);
        pend[b]     = 1'b1;
        exp_data[b] = ref_mem[w];
        exp_tag[b]  = next_tag;
        exp_hit[b]  = (hit_exp == 2'd2) ? mhit : hit_exp[0];
        if (op == OP_STORE) begin
            ref_mem[w] = data;
        end
        req_valid <= 1'b1;
        req_op    <= op;
        req_addr  <= addr;
        req_data  <= data;
        req_tag   <= next_tag;
        next_tag  = next_tag + 1'b1;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge clk);
        while ((busy_0 || busy_1) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (busy_0 || busy_1) begin
            $display("Timeout: a bank stayed busy for %0d cycles", TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_response(input int b, input logic [`L1_WORD_BITS-1:0] data,
                                  input logic [`L1_OOO_TAG_BITS-1:0] tag, input logic hit,
                                  inout logic ok);
        checks += 3;
        if (data !== exp_data[b]) begin
            $display("MISMATCH t=%0t resp_data_%0d expected %h got %h",
                     $time, b, exp_data[b], data);
            errors++;
            ok = 1'b0;
        end
        if (tag !== exp_tag[b]) begin
            $display("MISMATCH t=%0t resp_tag_%0d expected %h got %h", $time, b, exp_tag[b], tag);
            errors++;
            ok = 1'b0;
        end
        if (hit !== exp_hit[b]) begin
            $display("MISMATCH t=%0t resp_hit_%0d expected %b got %b", $time, b, exp_hit[b], hit);
            errors++;
            ok = 1'b0;
        end
    endtask

    // Sampled mid-cycle, where registered outputs are settled
    task automatic collect_responses(output logic ok);
        int n;
        n  = 0;
        ok = 1'b1;
        while ((pend[0] || pend[1]) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            if (pend[0] && resp_valid_0) begin
                lat[0] = n - 1;
                check_response(0, resp_data_0, resp_tag_0, resp_hit_0, ok);
                pend[0] = 1'b0;
            end
            if (pend[1] && resp_valid_1) begin
                lat[1] = n - 1;
                check_response(1, resp_data_1, resp_tag_1, resp_hit_1, ok);
                pend[1] = 1'b0;
            end
        end
        if (pend[0] || pend[1]) begin
            $display("Timeout: no response within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
            ok        = 1'b0;
        end
    endtask

    initial begin
        logic ok;
        int   b;
        void'($urandom(32'hfb8f_3f07));
        rst       = 1'b1;
        req_valid = 1'b0;
        req_op    = OP_NONE;
        req_addr  = '0;
        req_data  = '0;
        req_tag   = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        next_tag  = '0;
        n_entries = 0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            ref_mem[w] = 32'(w) ^ `L1_MEM_INIT_XOR;
        end
        for (int k = 0; k < 2; k++) begin
            pend[k] = 1'b0;
            for (int s = 0; s < SETS; s++) begin
                mdl_valid[k][s][0] = 1'b0;
                mdl_valid[k][s][1] = 1'b0;
                mdl_lru[k][s]      = 1'b0;
            end
        end
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checks++;
        if (busy_0 || busy_1 || resp_valid_0 || resp_valid_1) begin
            $display("Busy or response strobe high right after reset");
            errors++;
        end

        for (int i = 0; i < n_entries && !timed_out; i++) begin
            wait_idle();
            if (!timed_out) begin
                b = stim[i].addr[`L1_BANK_BIT];
                send_request(stim[i].op, stim[i].addr, stim[i].data, stim[i].hit_exp);
                @(posedge clk);
                if (stim[i].second) begin
                    // Other bank, next cycle
                    send_request(stim[i].op, stim[i].addr ^ 12'h010, ~stim[i].data, 2'd2);
                    @(posedge clk);
                end
                req_valid <= 1'b0;
                collect_responses(ok);
                if (ok && !stim[i].second) begin
                    checks++;
                    if (exp_hit[b] && lat[b] != HIT_LAT) begin
                        $display("MISMATCH t=%0t resp_valid_%0d latency expected %0d got %0d",
                                 $time, b, HIT_LAT, lat[b]);
                        errors++;
                        ok = 1'b0;
                    end else if (!exp_hit[b] && lat[b] < HIT_LAT + `L1_MEM_LATENCY) begin
                        $display("Miss on bank %0d answered after only %0d cycles", b, lat[b]);
                        errors++;
                        ok = 1'b0;
                    end
                end
                $display("test %0d %s addr %h%s %s", i,
                         (stim[i].op == OP_STORE) ? "store" : "load", stim[i].addr,
                         stim[i].second ? " with second bank" : "", ok ? "ok" : "FAILED");
            end
        end

        $display("tests %0d, checks %0d, errors %0d", n_entries, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/l1_cache_pkg.sv
src/cache_bank.sv
src/miss_arbiter.sv
src/backing_memory.sv
src/l1_cache_top.sv
testbench/tb_l1_cache.sv

//--- Bender.yml
package:
  name: l1_cache

sources:
  - include_dirs:
      - src
    files:
      - src/l1_cache_pkg.sv
      - src/cache_bank.sv
      - src/miss_arbiter.sv
      - src/backing_memory.sv
      - src/l1_cache_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/tb_l1_cache.sv
